//--- bench/simt_core_tb.sv
`include "simt_settings.svh"

module simt_core_tb
    import simt_pkg::*;
();

    localparam int NUM_TESTS  = 4;
    localparam int PROG_LEN   = 16;
    localparam int MAX_STORES = 24;
    localparam int MEM_WORDS  = 2 ** `SIMT_ADDR_WIDTH;
    localparam int TIMEOUT    = 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       start_i;
    addr_t      start_pc_i;
    logic       done_o;
    logic       imem_valid_o;
    addr_t      imem_addr_o;
    logic       imem_ready_i = 1'b0;
    instr_t     imem_data_i = '0;
    lane_mask_t dmem_wvalid_o;
    lane_addr_t dmem_waddr_o;
    lane_data_t dmem_wdata_o;
    lane_mask_t dmem_wready_i = '0;

    // One row of the stimulus table per test
    string  test_name [NUM_TESTS];
    addr_t  test_pc [NUM_TESTS];
    bit     test_stall [NUM_TESTS];
    instr_t prog [NUM_TESTS][PROG_LEN];
    int     prog_len [NUM_TESTS];
    int     exp_count [NUM_TESTS];
    int     exp_lane [NUM_TESTS][MAX_STORES];
    addr_t  exp_addr [NUM_TESTS][MAX_STORES];
    data_t  exp_data [NUM_TESTS][MAX_STORES];

    // Memory models
    instr_t imem [MEM_WORDS];
    int     imem_delay;
    int     dmem_delay [`SIMT_LANES];
    // Log tags hold the test number plus one
    int     log_tag [MEM_WORDS];
    int     log_lane [MEM_WORDS];
    data_t  log_data [MEM_WORDS];
    int     writes_in_test [NUM_TESTS];
    int     hold_violations [NUM_TESTS];

    logic       imem_hold = 1'b0;
    addr_t      imem_addr_prev = '0;
    lane_mask_t w_hold = '0;
    lane_addr_t waddr_prev = '0;
    lane_data_t wdata_prev = '0;

    int cur_test;
    bit stall_on;
    int errors;
    int test_errors;
    int failed_tests;

    simt_core dut_i (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .start_pc_i    (start_pc_i),
        .done_o        (done_o),
        .imem_valid_o  (imem_valid_o),
        .imem_addr_o   (imem_addr_o),
        .imem_ready_i  (imem_ready_i),
        .imem_data_i   (imem_data_i),
        .dmem_wvalid_o (dmem_wvalid_o),
        .dmem_waddr_o  (dmem_waddr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_wready_i (dmem_wready_i)
    );

    always #4 clk = ~clk;

    function automatic instr_t enc_reg(opcode_e op, int rd, int rs1, int rs2);
        return {op, reg_addr_t'(rd), reg_addr_t'(rs1), reg_addr_t'(rs2), 3'b000};
    endfunction

    function automatic instr_t enc_imm(opcode_e op, int rd, int rs1, int imm);
        return {op, reg_addr_t'(rd), reg_addr_t'(rs1), 6'(imm)};
    endfunction

    function automatic int pick_delay();
        return stall_on ? int'($urandom_range(3, 0)) : 0;
    endfunction

    task automatic add_word(input int t, input instr_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_store(input int t, input int lane, input int addr, input data_t value);
        exp_lane[t][exp_count[t]] = lane;
        exp_addr[t][exp_count[t]] = addr_t'(addr);
        exp_data[t][exp_count[t]] = value;
        exp_count[t]++;
    endtask

    // Store base in r0 is 8 times the lane index
    task automatic add_lane_base(input int t);
        add_word(t, enc_reg(ADD, 0, 7, 7));
        add_word(t, enc_reg(ADD, 0, 0, 0));
        add_word(t, enc_reg(ADD, 0, 0, 0));
    endtask

    task automatic build_arith(input int t, input string name, input bit stall);
        data_t r [1:6];
        test_name[t]  = name;
        test_pc[t]    = '0;
        test_stall[t] = stall;
        add_lane_base(t);
        add_word(t, enc_imm(ADDI, 1, 7, 5));
        add_word(t, enc_reg(ADD, 2, 1, 7));
        add_word(t, enc_reg(SUB, 3, 1, 2));
        add_word(t, enc_reg(MUL, 4, 2, 1));
        add_word(t, enc_reg(AND, 5, 2, 1));
        add_word(t, enc_reg(SLT, 6, 3, 7));
        for (int k = 1; k <= 6; k++) begin
            add_word(t, enc_imm(STORE, k, 0, k - 1));
        end
        add_word(t, enc_reg(HALT, 0, 0, 0));
        for (int l = 0; l < `SIMT_LANES; l++) begin
            r[1] = data_t'(l + 5);
            r[2] = r[1] + data_t'(l);
            // Negative result wraps at 16 bits
            r[3] = r[1] - r[2];
            r[4] = r[2] * r[1];
            r[5] = r[2] & r[1];
            // Minus the lane index compared with the lane index as signed words
            r[6] = data_t'($signed(r[3]) < $signed(data_t'(l)));
            for (int k = 1; k <= 6; k++) begin
                add_store(t, l, 8 * l + k - 1, r[k]);
            end
        end
    endtask

    task automatic build_mask(input int t);
        test_name[t]  = "mask";
        test_pc[t]    = addr_t'(24);
        test_stall[t] = 1'b0;
        add_lane_base(t);
        add_word(t, enc_reg(SETMASK, 0, 7, 0));
        add_word(t, enc_imm(ADDI, 1, 7, 20));
        add_word(t, enc_imm(STORE, 1, 0, 2));
        add_word(t, enc_reg(HALT, 0, 0, 0));
        // Bit 0 of the lane index is set in odd lanes only
        for (int l = 0; l < `SIMT_LANES; l++) begin
            if (l % 2 == 1) begin
                add_store(t, l, 8 * l + 2, data_t'(l + 20));
            end
        end
    endtask

    task automatic build_jump(input int t);
        test_name[t]  = "jump_restart";
        test_pc[t]    = addr_t'(8);
        test_stall[t] = 1'b0;
        add_lane_base(t);
        add_word(t, enc_imm(ADDI, 2, 7, 9));
        add_word(t, enc_imm(JMP, 0, 0, 2));
        add_word(t, enc_imm(STORE, 2, 0, 3));
        add_word(t, enc_imm(STORE, 2, 0, 4));
        add_word(t, enc_reg(HALT, 0, 0, 0));
        // All lanes store, so the mask left by the previous run is gone
        for (int l = 0; l < `SIMT_LANES; l++) begin
            add_store(t, l, 8 * l + 4, data_t'(l + 9));
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_program(input int t);
        for (int a = 0; a < MEM_WORDS; a++) begin
            // Stray fetches hit a HALT that carries its own address
            imem[a] = {4'hf, 4'h0, addr_t'(a)};
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[test_pc[t] + addr_t'(i)] = prog[t][i];
        end
    endtask

    task automatic wait_done(output bit ok);
        int cycles;
        cycles = 0;
        while (!done_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = done_o;
    endtask

    task automatic check_results(input int t);
        int a;
        for (int i = 0; i < exp_count[t]; i++) begin
            a = int'(exp_addr[t][i]);
            check_value($sformatf("%s written %0h", test_name[t], a), 32'd1,
                        32'(log_tag[a] == t + 1));
            check_value($sformatf("%s lane at %0h", test_name[t], a), 32'(exp_lane[t][i]),
                        32'(log_lane[a]));
            check_value($sformatf("%s data at %0h", test_name[t], a), 32'(exp_data[t][i]),
                        32'(log_data[a]));
        end
        check_value($sformatf("%s write count", test_name[t]), 32'(exp_count[t]),
                    32'(writes_in_test[t]));
        check_value($sformatf("%s handshake errors", test_name[t]), 32'd0,
                    32'(hold_violations[t]));
        // Halted warp must stay parked
        repeat (20) begin
            @(negedge clk);
            check_value($sformatf("%s done_o held", test_name[t]), 32'd1, 32'(done_o));
            check_value($sformatf("%s fetch idle", test_name[t]), 32'd0, 32'(imem_valid_o));
        end
    endtask

    // Ready generators drive on the falling edge
    always @(negedge clk) begin
        if (imem_ready_i) begin
            imem_ready_i = 1'b0;
            imem_delay   = pick_delay();
        end else if (imem_valid_o) begin
            if (imem_delay == 0) begin
                imem_ready_i = 1'b1;
                imem_data_i  = imem[imem_addr_o];
            end else begin
                imem_delay--;
            end
        end
        for (int l = 0; l < `SIMT_LANES; l++) begin
            if (dmem_wready_i[l]) begin
                dmem_wready_i[l] = 1'b0;
                dmem_delay[l]    = pick_delay();
            end else if (dmem_wvalid_o[l]) begin
                if (dmem_delay[l] == 0) begin
                    dmem_wready_i[l] = 1'b1;
                end else begin
                    dmem_delay[l]--;
                end
            end
        end
    end

    // Handshake monitor and write log
    always @(posedge clk) begin
        if (!reset) begin
            if (imem_hold && (!imem_valid_o || imem_addr_o != imem_addr_prev)) begin
                $display("Fetch request dropped or moved before ready in test %0d", cur_test);
                hold_violations[cur_test]++;
            end
            for (int l = 0; l < `SIMT_LANES; l++) begin
                if (w_hold[l] && (!dmem_wvalid_o[l] || dmem_waddr_o[l] != waddr_prev[l] ||
                                  dmem_wdata_o[l] != wdata_prev[l])) begin
                    $display("Lane %0d write dropped or changed before ready", l);
                    hold_violations[cur_test]++;
                end
                if (dmem_wvalid_o[l] && dmem_wready_i[l]) begin
                    log_tag[dmem_waddr_o[l]]  = cur_test + 1;
                    log_lane[dmem_waddr_o[l]] = l;
                    log_data[dmem_waddr_o[l]] = dmem_wdata_o[l];
                    writes_in_test[cur_test]++;
                end
            end
        end
        imem_hold      = imem_valid_o && !imem_ready_i;
        imem_addr_prev = imem_addr_o;
        w_hold         = dmem_wvalid_o & ~dmem_wready_i;
        waddr_prev     = dmem_waddr_o;
        wdata_prev     = dmem_wdata_o;
    end

    initial begin
        bit ok;
        int seed;
        reset      = 1'b1;
        start_i    = 1'b0;
        start_pc_i = '0;
        seed       = $urandom(32'h8d1b74ee);
        build_arith(0, "arith", 1'b0);
        build_mask(1);
        build_jump(2);
        build_arith(3, "arith_stall", 1'b1);
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset done_o", 32'd0, 32'(done_o));
        check_value("reset imem_valid_o", 32'd0, 32'(imem_valid_o));
        check_value("reset dmem_wvalid_o", 32'd0, 32'(dmem_wvalid_o));
        ok = 1'b1;
        for (int t = 0; t < NUM_TESTS && ok; t++) begin
            test_errors = 0;
            load_program(t);
            cur_test   = t;
            stall_on   = test_stall[t];
            start_pc_i = test_pc[t];
            start_i    = 1'b1;
            @(negedge clk);
            start_i = 1'b0;
            wait_done(ok);
            if (!ok) begin
                $display("Test %s timed out waiting for done_o", test_name[t]);
                errors++;
                failed_tests++;
            end else begin
                check_results(t);
                if (test_errors == 0) begin
                    $display("test %s: ok", test_name[t]);
                end else begin
                    $display("test %s: %0d checks failed", test_name[t], test_errors);
                    failed_tests++;
                end
            end
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- design/decode_if.sv
interface decode_if
    import simt_pkg::*;
();

    opcode_e   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;

    // Already sign-extended to the lane width
    data_t     imm;

    // High for the ALU opcodes that write rd
    logic      reg_write;

    modport driver (
        output opcode, rd, rs1, rs2, imm, reg_write
    );

    modport reader (
        input opcode, rd, rs1, rs2, imm, reg_write
    );

endinterface

//--- design/fetch_decode.sv
module fetch_decode
    import simt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     fetch_req_i,
    input  addr_t    pc_i,
    output logic     imem_valid_o,
    output addr_t    imem_addr_o,
    input  logic     imem_ready_i,
    input  instr_t   imem_data_i,
    output logic     fetch_done_o,
    decode_if.driver dec
);

    instr_t ir_q;

    // Request stays up for all of FETCH, pc does not move meanwhile
    assign imem_valid_o = fetch_req_i;
    assign imem_addr_o  = pc_i;
    assign fetch_done_o = fetch_req_i && imem_ready_i;

    // Cleared word decodes as NOP
    always_ff @(posedge clk) begin
        if (reset) begin
            ir_q <= '0;
        end else if (fetch_done_o) begin
            ir_q <= imem_data_i;
        end
    end

    always_comb begin
        case (ir_q[15:12])
            ADD, SUB, MUL, AND, SLT, ADDI, STORE, SETMASK, JMP, HALT: begin
                dec.opcode = opcode_e'(ir_q[15:12]);
            end
            default: begin
                dec.opcode = NOP;
            end
        endcase
    end

    assign dec.rd  = ir_q[11:9];
    assign dec.rs1 = ir_q[8:6];
    assign dec.rs2 = ir_q[5:3];

    // Immediate shares bits with rs2
    assign dec.imm = {{($bits(data_t) - 6){ir_q[5]}}, ir_q[5:0]};

    assign dec.reg_write = (dec.opcode == ADD) || (dec.opcode == SUB) ||
                           (dec.opcode == MUL) || (dec.opcode == AND) ||
                           (dec.opcode == SLT) || (dec.opcode == ADDI);

endmodule

//--- design/lane_execute.sv
`include "simt_settings.svh"

module lane_execute
    import simt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    decode_if.reader   dec,
    input  logic       exec_en_i,
    input  logic       pc_load_i,
    input  lane_data_t rs1_data_i,
    input  lane_data_t rs2_data_i,
    output lane_data_t result_o,
    output lane_mask_t mask_o
);

    lane_mask_t mask_q;

    // Same ALU in every lane, results wrap at the data width
    always_comb begin
        for (int l = 0; l < `SIMT_LANES; l++) begin
            case (dec.opcode)
                ADD:         result_o[l] = rs1_data_i[l] + rs2_data_i[l];
                SUB:         result_o[l] = rs1_data_i[l] - rs2_data_i[l];
                MUL:         result_o[l] = rs1_data_i[l] * rs2_data_i[l];
                AND:         result_o[l] = rs1_data_i[l] & rs2_data_i[l];
                SLT: begin
                    result_o[l] = ($signed(rs1_data_i[l]) < $signed(rs2_data_i[l])) ?
                                  data_t'(1) : data_t'(0);
                end
                // Store address comes out of the same adder
                ADDI, STORE: result_o[l] = rs1_data_i[l] + dec.imm;
                default:     result_o[l] = '0;
            endcase
        end
    end

    // A new launch starts with every lane enabled
    always_ff @(posedge clk) begin
        if (reset || pc_load_i) begin
            mask_q <= '1;
        end else if (exec_en_i && dec.opcode == SETMASK) begin
            // Gather bit 0 of rs1 from all lanes, active or not
            for (int l = 0; l < `SIMT_LANES; l++) begin
                mask_q[l] <= rs1_data_i[l][0];
            end
        end
    end

    assign mask_o = mask_q;

endmodule

//--- design/pc_counter.sv
module pc_counter
    import simt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  addr_t    start_pc_i,
    input  logic     pc_load_i,
    input  logic     pc_update_i,
    decode_if.reader dec,
    output addr_t    pc_o
);

    addr_t pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else if (pc_load_i) begin
            pc_q <= start_pc_i;
        end else if (pc_update_i) begin
            // Relative jump wraps in the instruction address space
            if (dec.opcode == JMP) begin
                pc_q <= pc_q + addr_t'(dec.imm);
            end else begin
                pc_q <= pc_q + addr_t'(1);
            end
        end
    end

    assign pc_o = pc_q;

endmodule

//--- design/simt_core.sv
module simt_core
    import simt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_i,
    input  addr_t      start_pc_i,
    output logic       done_o,
    output logic       imem_valid_o,
    output addr_t      imem_addr_o,
    input  logic       imem_ready_i,
    input  instr_t     imem_data_i,
    output lane_mask_t dmem_wvalid_o,
    output lane_addr_t dmem_waddr_o,
    output lane_data_t dmem_wdata_o,
    input  lane_mask_t dmem_wready_i
);

    logic       fetch_req;
    logic       fetch_done;
    logic       exec_en;
    logic       store_go;
    logic       store_busy;
    logic       pc_load;
    logic       pc_update;
    addr_t      pc;
    lane_mask_t mask;
    lane_data_t rs1_data;
    lane_data_t rs2_data;
    lane_data_t rd_data;
    lane_data_t result;

    decode_if dec ();

    warp_controller u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .done_o       (done_o),
        .fetch_done_i (fetch_done),
        .store_busy_i (store_busy),
        .dec          (dec.reader),
        .fetch_req_o  (fetch_req),
        .exec_en_o    (exec_en),
        .store_go_o   (store_go),
        .pc_load_o    (pc_load),
        .pc_update_o  (pc_update)
    );

    pc_counter u_pc (
        .clk         (clk),
        .reset       (reset),
        .start_pc_i  (start_pc_i),
        .pc_load_i   (pc_load),
        .pc_update_i (pc_update),
        .dec         (dec.reader),
        .pc_o        (pc)
    );

    fetch_decode u_fetch (
        .clk          (clk),
        .reset        (reset),
        .fetch_req_i  (fetch_req),
        .pc_i         (pc),
        .imem_valid_o (imem_valid_o),
        .imem_addr_o  (imem_addr_o),
        .imem_ready_i (imem_ready_i),
        .imem_data_i  (imem_data_i),
        .fetch_done_o (fetch_done),
        .dec          (dec.driver)
    );

    vector_reg_file u_regs (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec.reader),
        .exec_en_i  (exec_en),
        .mask_i     (mask),
        .wdata_i    (result),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_data_o  (rd_data)
    );

    lane_execute u_exec (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec.reader),
        .exec_en_i  (exec_en),
        .pc_load_i  (pc_load),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (result),
        .mask_o     (mask)
    );

    // Store address is the ALU sum, store data is register rd
    store_unit u_store (
        .clk           (clk),
        .reset         (reset),
        .store_go_i    (store_go),
        .mask_i        (mask),
        .addr_i        (result),
        .data_i        (rd_data),
        .store_busy_o  (store_busy),
        .dmem_wvalid_o (dmem_wvalid_o),
        .dmem_waddr_o  (dmem_waddr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_wready_i (dmem_wready_i)
    );

endmodule

//--- design/simt_pkg.sv
`include "simt_settings.svh"

package simt_pkg;

    typedef logic [`SIMT_DATA_WIDTH-1:0] data_t;
    typedef logic [`SIMT_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`SIMT_INSTR_WIDTH-1:0] instr_t;

    // Register index as carried in the rd, rs1 and rs2 fields
    typedef logic [2:0] reg_addr_t;

    // One bit, data word or address per lane
    typedef logic [`SIMT_LANES-1:0] lane_mask_t;
    typedef data_t [`SIMT_LANES-1:0] lane_data_t;
    typedef addr_t [`SIMT_LANES-1:0] lane_addr_t;

    typedef enum logic [3:0] {
        NOP     = 4'h0,
        ADD     = 4'h1,
        SUB     = 4'h2,
        MUL     = 4'h3,
        AND     = 4'h4,
        SLT     = 4'h5,
        ADDI    = 4'h6,
        STORE   = 4'h7,
        SETMASK = 4'h8,
        JMP     = 4'h9,
        HALT    = 4'hf
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        WAIT,
        UPDATE,
        DONE
    } warp_state_e;

endpackage

//--- design/store_unit.sv
`include "simt_settings.svh"

module store_unit
    import simt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       store_go_i,
    input  lane_mask_t mask_i,
    input  lane_data_t addr_i,
    input  lane_data_t data_i,
    output logic       store_busy_o,
    output lane_mask_t dmem_wvalid_o,
    output lane_addr_t dmem_waddr_o,
    output lane_data_t dmem_wdata_o,
    input  lane_mask_t dmem_wready_i
);

    lane_mask_t pending_q;
    lane_addr_t addr_q;
    lane_data_t data_q;

    // Each lane retires on its own ready
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else if (store_go_i) begin
            pending_q <= mask_i;
        end else begin
            pending_q <= pending_q & ~dmem_wready_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `SIMT_LANES; l++) begin
            if (store_go_i && mask_i[l]) begin
                // Low bits of the lane result form the address
                addr_q[l] <= addr_t'(addr_i[l]);
                data_q[l] <= data_i[l];
            end
        end
    end

    assign dmem_wvalid_o = pending_q;
    assign dmem_waddr_o  = addr_q;
    assign dmem_wdata_o  = data_q;
    assign store_busy_o  = |pending_q;

endmodule

//--- design/vector_reg_file.sv
`include "simt_settings.svh"

module vector_reg_file
    import simt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    decode_if.reader   dec,
    input  logic       exec_en_i,
    input  lane_mask_t mask_i,
    input  lane_data_t wdata_i,
    output lane_data_t rs1_data_o,
    output lane_data_t rs2_data_o,
    output lane_data_t rd_data_o
);

    // Top register is the lane index, so it needs no storage
    localparam int LANE_REG = `SIMT_REGS - 1;

    data_t regs_q [`SIMT_LANES][LANE_REG];

    function automatic data_t read_port(input int lane, input reg_addr_t addr);
        if (addr == reg_addr_t'(LANE_REG)) begin
            return data_t'(lane);
        end
        return regs_q[lane][addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < `SIMT_LANES; l++) begin
                for (int r = 0; r < LANE_REG; r++) begin
                    regs_q[l][r] <= '0;
                end
            end
        end else if (exec_en_i && dec.reg_write && dec.rd != reg_addr_t'(LANE_REG)) begin
            // Inactive lanes keep their old value
            for (int l = 0; l < `SIMT_LANES; l++) begin
                if (mask_i[l]) begin
                    regs_q[l][dec.rd] <= wdata_i[l];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < `SIMT_LANES; l++) begin
            rs1_data_o[l] = read_port(l, dec.rs1);
            rs2_data_o[l] = read_port(l, dec.rs2);
            rd_data_o[l]  = read_port(l, dec.rd);
        end
    end

endmodule

//--- design/warp_controller.sv
module warp_controller
    import simt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start_i,
    output logic     done_o,
    input  logic     fetch_done_i,
    input  logic     store_busy_i,
    decode_if.reader dec,
    output logic     fetch_req_o,
    output logic     exec_en_o,
    output logic     store_go_o,
    output logic     pc_load_o,
    output logic     pc_update_o
);

    warp_state_e state_q;
    warp_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (start_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (fetch_done_i) begin
                    state_d = DECODE;
                end
            end
            DECODE: begin
                state_d = EXECUTE;
            end
            EXECUTE: begin
                // Only stores have to wait for the memory side
                state_d = (dec.opcode == STORE) ? WAIT : UPDATE;
            end
            WAIT: begin
                if (!store_busy_i) begin
                    state_d = UPDATE;
                end
            end
            UPDATE: begin
                state_d = (dec.opcode == HALT) ? DONE : FETCH;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes decoded straight from the state
    assign pc_load_o   = start_i && (state_q == IDLE || state_q == DONE);
    assign fetch_req_o = (state_q == FETCH);
    assign exec_en_o   = (state_q == EXECUTE);
    assign store_go_o  = (state_q == EXECUTE) && (dec.opcode == STORE);
    assign pc_update_o = (state_q == UPDATE);
    assign done_o      = (state_q == DONE);

endmodule

//--- list.f
+incdir+.
design/simt_pkg.sv
design/decode_if.sv
design/warp_controller.sv
design/pc_counter.sv
design/fetch_decode.sv
design/vector_reg_file.sv
design/lane_execute.sv
design/store_unit.sv
design/simt_core.sv
bench/simt_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module simt_core_tb -o simt_core_sim
./obj_dir/simt_core_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

//--- simt_settings.svh
`ifndef SIMT_SETTINGS_SVH
`define SIMT_SETTINGS_SVH

// Warp geometry
`define SIMT_LANES 4

// Last register of each lane reads back the lane index
`define SIMT_REGS 8

// Datapath widths
`define SIMT_DATA_WIDTH 16
`define SIMT_ADDR_WIDTH 8

// Fields sit in bits 15 to 0 of the instruction word
`define SIMT_INSTR_WIDTH 16

`endif
